// ==== tests/bp_patterns.txt ====
# name en pc_now upd_vld upd_pc upd_slot upd_target upd_flags upd_taken ex_vld ex_wrong
# then expected pc_new branch reason, every value after the name in hex
reset_empty   0 00001000 0 00000000 0 00000000 0 0 0 0 00001008 0 0
reset_empty   0 00001014 0 00000000 0 00000000 0 0 0 0 00001018 0 1
counter_train 0 00004020 1 00004020 0 00004100 1 1 0 0 00004028 0 0
counter_train 0 00004020 1 00004020 0 00004100 1 1 0 0 00004028 0 0
counter_train 0 00004020 1 00004020 0 00004100 1 1 0 0 00004028 0 0
counter_train 0 00004020 1 00004020 0 00004100 1 1 0 0 00004028 0 0
counter_train 0 00004020 1 00004024 1 00004200 1 1 0 0 00004100 1 0
slot_pick     0 00004024 1 00004024 1 00004200 1 1 0 0 00004028 0 1
slot_pick     0 00004020 1 00004024 1 00004200 1 1 0 0 00004100 1 0
slot_pick     0 00004024 1 00004024 1 00004200 1 1 0 0 00004028 0 1
slot_pick     0 00004024 0 00000000 0 00000000 0 0 0 0 00004200 1 1
slot_pick     0 00004020 1 00004020 0 00004100 1 0 0 0 00004100 1 0
counter_flip  0 00004020 1 00004020 0 00004100 1 0 0 0 00004200 1 1
counter_flip  0 00004020 1 00004020 0 00004100 1 1 0 0 00004200 1 1
counter_flip  0 00004020 1 00004020 0 00004100 1 0 0 0 00004200 1 1
guess_flush   1 00004020 0 00000000 0 00000000 0 0 0 0 00004200 1 1
guess_flush   0 00004020 0 00000000 0 00000000 0 0 0 0 00004100 1 0
guess_flush   1 00004020 0 00000000 0 00000000 0 0 1 1 00004100 1 0
guess_flush   0 00004020 0 00000000 0 00000000 0 0 0 0 00004200 1 1
tag_miss      0 00014020 0 00000000 0 00000000 0 0 0 0 00014028 0 0

// ==== vlog.f ====
hw/bp_pkg.sv
hw/target_table.sv
hw/history_table.sv
hw/guess_log.sv
hw/predict_ctrl.sv
hw/branch_predictor.sv
tests/bp_properties.sv
tests/bp_checker.sv
tests/tb_branch_predictor.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_branch_predictor \
    -Mdir obj_dir -o sim_branch_predictor
./obj_dir/sim_branch_predictor | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== tests/tb_branch_predictor.sv ====
////////////////////
// Branch predictor testbench
// Replays the pattern file rows against the DUT
////////////////////
`timescale 1ns/1ps

module tb_branch_predictor import bp_pkg::*; ();

    logic                  clk;
    logic                  rstn;
    logic                  en;
    logic [addr_width-1:0] pc_now;
    logic                  upd_vld;
    logic                  upd_slot;
    logic                  upd_taken;
    logic [addr_width-1:0] upd_pc;
    logic [addr_width-1:0] upd_target;
    logic [1:0]            upd_flags;
    logic                  ex_vld;
    logic                  ex_wrong;
    logic [addr_width-1:0] pc_new;
    logic                  branch;
    logic                  reason;

    // Expectations travel to the checker with each row
    logic                  chk_vld;
    logic                  chk_last;
    logic [127:0]          test_name;
    logic [addr_width-1:0] exp_pc_new;
    logic                  exp_branch;
    logic                  exp_reason;
    logic                  chk_done;
    int                    test_count;
    int                    fail_count;
    int                    err_count;
    int                    bad_rows;
    string                 rows [$];
    bit                    rows_loaded;

    branch_predictor u_branch_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .en         (en),
        .pc_now     (pc_now),
        .upd_vld    (upd_vld),
        .upd_slot   (upd_slot),
        .upd_taken  (upd_taken),
        .upd_pc     (upd_pc),
        .upd_target (upd_target),
        .upd_flags  (upd_flags),
        .ex_vld     (ex_vld),
        .ex_wrong   (ex_wrong),
        .pc_new     (pc_new),
        .branch     (branch),
        .reason     (reason)
    );

    bp_checker u_bp_checker (
        .clk        (clk),
        .chk_vld    (chk_vld),
        .chk_last   (chk_last),
        .test_name  (test_name),
        .exp_pc_new (exp_pc_new),
        .exp_branch (exp_branch),
        .exp_reason (exp_reason),
        .pc_new     (pc_new),
        .branch     (branch),
        .reason     (reason),
        .done       (chk_done),
        .test_count (test_count),
        .fail_count (fail_count),
        .err_count  (err_count)
    );

    always #20 clk = ~clk;

    ////////////////////
    // Pattern rows
    ////////////////////
    task automatic load_rows(input int fd);
        string line;
        int    code;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // Skip comment and blank lines
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                rows.push_back(line);
            end
        end
    endtask

    task automatic drive_row(input string line, input bit last);
        logic [127:0] name;
        logic [31:0]  f [13];
        int           n;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name, f[0], f[1],
                    f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
        if (n != 14) begin
            $display("pattern row could not be parsed: %0s", line);
            bad_rows++;
        end
        en         <= f[0][0];
        pc_now     <= f[1];
        upd_vld    <= f[2][0];
        upd_pc     <= f[3];
        upd_slot   <= f[4][0];
        upd_target <= f[5];
        upd_flags  <= f[6][1:0];
        upd_taken  <= f[7][0];
        ex_vld     <= f[8][0];
        ex_wrong   <= f[9][0];
        exp_pc_new <= f[10];
        exp_branch <= f[11][0];
        exp_reason <= f[12][0];
        test_name  <= name;
        chk_last   <= last;
        chk_vld    <= 1'b1;
    endtask

    initial begin
        int fd;
        clk         = 1'b0;
        bad_rows    = 0;
        rows_loaded = 1'b0;
        rstn       <= 1'b0;
        en         <= 1'b0;
        pc_now     <= '0;
        upd_vld    <= 1'b0;
        upd_slot   <= 1'b0;
        upd_taken  <= 1'b0;
        upd_pc     <= '0;
        upd_target <= '0;
        upd_flags  <= '0;
        ex_vld     <= 1'b0;
        ex_wrong   <= 1'b0;
        chk_vld    <= 1'b0;
        chk_last   <= 1'b0;
        test_name  <= '0;
        exp_pc_new <= '0;
        exp_branch <= 1'b0;
        exp_reason <= 1'b0;

        fd = $fopen("tests/bp_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file tests/bp_patterns.txt could not be opened");
            $display("TESTS FAILED");
            $finish;
        end else begin
            load_rows(fd);
            $fclose(fd);
            rows_loaded = 1'b1;

            repeat (5) @(posedge clk);
            rstn <= 1'b1;

            for (int i = 0; i < rows.size(); i++) begin
                @(posedge clk);
                drive_row(rows[i], i == rows.size() - 1);
            end
            @(posedge clk);
            chk_vld <= 1'b0;
            wait (chk_done);

            $display(
                "summary: %0d tests, %0d failed, %0d mismatches, %0d bad rows, %0d assert fails",
                test_count, fail_count, err_count, bad_rows,
                u_branch_predictor.u_bp_properties.assert_fails);
            if (test_count > 0 && fail_count == 0 && err_count == 0 && bad_rows == 0 &&
                u_branch_predictor.u_bp_properties.assert_fails == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

    // Watchdog allows one clock period per row plus 20 cycles
    initial begin
        wait (rows_loaded);
        #((rows.size() + 20) * 40);
        $display("timeout: the checker did not finish all %0d rows in time", rows.size());
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== tests/bp_checker.sv ====
////////////////////
// Predictor output checker
// Compares each row against the pattern expectations, one line per test
////////////////////
`timescale 1ns/1ps

module bp_checker import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  chk_vld,
    input  logic                  chk_last,
    input  logic [127:0]          test_name,
    input  logic [addr_width-1:0] exp_pc_new,
    input  logic                  exp_branch,
    input  logic                  exp_reason,
    input  logic [addr_width-1:0] pc_new,
    input  logic                  branch,
    input  logic                  reason,
    output logic                  done,
    output int                    test_count,
    output int                    fail_count,
    output int                    err_count
);

    logic [127:0] cur_name;
    int           cur_errs;
    int           cur_rows;
    bit           in_test;

    initial begin
        done       = 1'b0;
        test_count = 0;
        fail_count = 0;
        err_count  = 0;
        cur_name   = '0;
        cur_errs   = 0;
        cur_rows   = 0;
        in_test    = 1'b0;
    end

    task automatic compare_field(input string field, input logic [addr_width-1:0] exp,
                                 input logic [addr_width-1:0] act);
        if (exp !== act) begin
            $display("error: test %0s, %0s expected %h, actual %h", cur_name, field, exp, act);
            cur_errs++;
            err_count++;
        end
    endtask

    task close_test;
        test_count++;
        if (cur_errs == 0) begin
            $display("test %0s: %0d rows, ok", cur_name, cur_rows);
        end else begin
            $display("test %0s: %0d rows, %0d mismatches", cur_name, cur_rows, cur_errs);
            fail_count++;
        end
        in_test = 1'b0;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (chk_vld) begin
            if (in_test && test_name != cur_name) begin
                close_test();
            end
            if (!in_test) begin
                cur_name = test_name;
                cur_errs = 0;
                cur_rows = 0;
                in_test  = 1'b1;
            end
            cur_rows++;
            compare_field("pc_new", exp_pc_new, pc_new);
            compare_field("branch", addr_width'(exp_branch), addr_width'(branch));
            compare_field("reason", addr_width'(exp_reason), addr_width'(reason));
            if (chk_last) begin
                close_test();
                done = 1'b1;
            end
        end
    end

endmodule

// ==== tests/bp_properties.sv ====
////////////////////
// Branch predictor output properties
// Slot selection and next pc alignment rules
////////////////////
`timescale 1ns/1ps

module bp_properties import bp_pkg::*; (
    input logic                  clk,
    input logic                  rstn,
    input logic [addr_width-1:0] pc_now,
    input logic [addr_width-1:0] pc_new,
    input logic                  branch,
    input logic                  reason
);

    int assert_fails = 0;

    // Fetch at offset 4 can only name slot 2
    reason_at_offset4: assert property (
        @(posedge clk) disable iff (!rstn) pc_now[2] |-> reason
    ) else begin
        $error("reason is low for a fetch at offset 4");
        assert_fails++;
    end

    pc_new_aligned: assert property (
        @(posedge clk) disable iff (!rstn) pc_new[1:0] == 2'b00
    ) else begin
        $error("pc_new is not word aligned");
        assert_fails++;
    end

    // No branch means the next aligned pair
    fall_through_pair: assert property (
        @(posedge clk) disable iff (!rstn)
        !branch |-> pc_new == (pc_now | addr_width'(7)) + addr_width'(1)
    ) else begin
        $error("pc_new is not the next pair while branch is low");
        assert_fails++;
    end

endmodule

bind branch_predictor bp_properties u_bp_properties (
    .clk    (clk),
    .rstn   (rstn),
    .pc_now (pc_now),
    .pc_new (pc_new),
    .branch (branch),
    .reason (reason)
);

// ==== hw/branch_predictor.sv ====
////////////////////
// Branch predictor top
// Two-wide fetch predictor built from three tables and a control block
////////////////////
`timescale 1ns/1ps

module branch_predictor import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  en,
    input  logic [addr_width-1:0] pc_now,
    input  logic                  upd_vld,
    input  logic                  upd_slot,
    input  logic                  upd_taken,
    input  logic [addr_width-1:0] upd_pc,
    input  logic [addr_width-1:0] upd_target,
    input  logic [1:0]            upd_flags,
    input  logic                  ex_vld,
    input  logic                  ex_wrong,
    output logic [addr_width-1:0] pc_new,
    output logic                  branch,
    output logic                  reason
);

    logic                     exist1;
    logic                     exist2;
    logic [addr_width-1:0]    info1;
    logic [addr_width-1:0]    info2;
    logic                     past_vld1;
    logic                     past_vld2;
    logic [hist_width-1:0]    past1;
    logic [hist_width-1:0]    past2;
    logic [2*guess_width-1:0] guess_rdata;
    logic [2*guess_width-1:0] guess_wdata;
    logic                     in_guess1;
    logic                     in_guess2;
    logic                     in_guess1_set;
    logic                     in_guess2_set;

    target_table u_target_table (
        .clk        (clk),
        .rstn       (rstn),
        .pc_now     (pc_now),
        .upd_vld    (upd_vld),
        .upd_pc     (upd_pc),
        .upd_slot   (upd_slot),
        .upd_target (upd_target),
        .upd_flags  (upd_flags),
        .exist1     (exist1),
        .exist2     (exist2),
        .info1      (info1),
        .info2      (info2)
    );

    history_table u_history_table (
        .clk       (clk),
        .rstn      (rstn),
        .pc_now    (pc_now),
        .upd_vld   (upd_vld),
        .upd_pc    (upd_pc),
        .upd_slot  (upd_slot),
        .upd_taken (upd_taken),
        .past_vld1 (past_vld1),
        .past_vld2 (past_vld2),
        .past1     (past1),
        .past2     (past2)
    );

    guess_log u_guess_log (
        .clk           (clk),
        .rstn          (rstn),
        .en            (en),
        .pc_now        (pc_now),
        .ex_vld        (ex_vld),
        .ex_wrong      (ex_wrong),
        .guess_wdata   (guess_wdata),
        .in_guess1_set (in_guess1_set),
        .in_guess2_set (in_guess2_set),
        .guess_rdata   (guess_rdata),
        .in_guess1     (in_guess1),
        .in_guess2     (in_guess2)
    );

    predict_ctrl u_predict_ctrl (
        .pc_now        (pc_now),
        .exist1        (exist1),
        .exist2        (exist2),
        .info1         (info1),
        .info2         (info2),
        .past_vld1     (past_vld1),
        .past_vld2     (past_vld2),
        .past1         (past1),
        .past2         (past2),
        .guess_rdata   (guess_rdata),
        .in_guess1     (in_guess1),
        .in_guess2     (in_guess2),
        .guess_wdata   (guess_wdata),
        .in_guess1_set (in_guess1_set),
        .in_guess2_set (in_guess2_set),
        .pc_new        (pc_new),
        .branch        (branch),
        .reason        (reason)
    );

endmodule

// ==== hw/predict_ctrl.sv ====
////////////////////
// Prediction control
// Per-slot taken decisions, slot selection and next fetch address
////////////////////
`timescale 1ns/1ps

module predict_ctrl import bp_pkg::*; (
    input  logic [addr_width-1:0]    pc_now,
    input  logic                     exist1,
    input  logic                     exist2,
    input  logic [addr_width-1:0]    info1,
    input  logic [addr_width-1:0]    info2,
    input  logic                     past_vld1,
    input  logic                     past_vld2,
    input  logic [hist_width-1:0]    past1,
    input  logic [hist_width-1:0]    past2,
    input  logic [2*guess_width-1:0] guess_rdata,
    input  logic                     in_guess1,
    input  logic                     in_guess2,
    output logic [2*guess_width-1:0] guess_wdata,
    output logic                     in_guess1_set,
    output logic                     in_guess2_set,
    output logic [addr_width-1:0]    pc_new,
    output logic                     branch,
    output logic                     reason
);

    logic [guess_width-1:0] hist1;
    logic [guess_width-1:0] hist2;
    logic                   vote1;
    logic                   vote2;
    logic                   back1;
    logic                   back2;
    logic                   take1;
    logic                   take2;
    logic                   slot2_only;
    logic                   slot2_reached;
    logic [addr_width-3:0]  target;
    logic [addr_width-1:0]  fall_through;

    ////////////////////
    // Per-slot decision
    ////////////////////

    // Logged history wins over the trained one while a guess is pending
    assign hist1 = in_guess1 ? guess_rdata[2*guess_width-1 -: guess_width]
                             : past1[hist_lo +: guess_width];
    assign hist2 = in_guess2 ? guess_rdata[guess_width-1:0]
                             : past2[hist_lo +: guess_width];

    // Counter MSB is the vote
    assign vote1 = past1[2*hist1 + 1];
    assign vote2 = past2[2*hist2 + 1];

    // Backward branches are assumed taken when untrained
    assign back1 = info1[addr_width-1:2] < pc_now[addr_width-1:2];
    assign back2 = info2[addr_width-1:2] < pc_now[addr_width-1:2];

    always_comb begin
        if (!exist1) begin
            take1 = 1'b0;
        end else if (past_vld1) begin
            take1 = vote1;
        end else begin
            take1 = info1[info_uncond] | back1;
        end

        if (!exist2) begin
            take2 = 1'b0;
        end else if (past_vld2) begin
            take2 = vote2;
        end else begin
            take2 = info2[info_uncond] | back2;
        end
    end

    ////////////////////
    // Slot selection
    ////////////////////

    // Fetch into the second word skips slot 1 entirely
    assign slot2_only = pc_now[2];

    assign branch = slot2_only ? take2 : (take1 | take2);
    assign reason = slot2_only ? 1'b1 : (~take1 & take2);

    assign target       = reason ? info2[addr_width-1:2] : info1[addr_width-1:2];
    assign fall_through = {pc_now[addr_width-1:3], 3'b000} + addr_width'(8);
    assign pc_new       = branch ? {target, 2'b00} : fall_through;

    // Slot 2 only executes when slot 1 is skipped or falls through
    assign slot2_reached = slot2_only | ~take1;

    assign in_guess1_set = ~slot2_only & exist1 & past_vld1 & info1[info_cond];
    assign in_guess2_set = slot2_reached & exist2 & past_vld2 & info2[info_cond];

    // Shift the predicted outcome into each slot history
    assign guess_wdata = {hist1[0], branch & ~reason, hist2[0], branch & reason};

endmodule

// ==== hw/guess_log.sv ====
////////////////////
// Guess log
// Speculative history of unresolved predictions, flushed on a mispredict
////////////////////
`timescale 1ns/1ps

module guess_log import bp_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     en,
    input  logic [addr_width-1:0]    pc_now,
    input  logic                     ex_vld,
    input  logic                     ex_wrong,
    input  logic [2*guess_width-1:0] guess_wdata,
    input  logic                     in_guess1_set,
    input  logic                     in_guess2_set,
    output logic [2*guess_width-1:0] guess_rdata,
    output logic                     in_guess1,
    output logic                     in_guess2
);

    logic [table_depth-1:0]   idx;
    logic [2*guess_width-1:0] guess_mem [table_size];
    logic [table_size-1:0]    in_guess1_q;
    logic [table_size-1:0]    in_guess2_q;
    logic                     flush;

    assign idx   = pc_now[idx_lo +: table_depth];
    assign flush = ex_vld && ex_wrong;

    // Slot 1 history in the upper half, slot 2 in the lower half
    always_ff @(posedge clk) begin
        if (en) begin
            guess_mem[idx] <= guess_wdata;
        end
    end

    // A flag stays up until execute reports a wrong prediction
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_guess1_q <= '0;
            in_guess2_q <= '0;
        end else if (en) begin
            if (flush) begin
                in_guess1_q <= '0;
                in_guess2_q <= '0;
            end else begin
                in_guess1_q[idx] <= in_guess1_q[idx] | in_guess1_set;
                in_guess2_q[idx] <= in_guess2_q[idx] | in_guess2_set;
            end
        end
    end

    assign guess_rdata = guess_mem[idx];
    assign in_guess1   = in_guess1_q[idx];
    assign in_guess2   = in_guess2_q[idx];

endmodule

// ==== hw/history_table.sv ====
////////////////////
// History table
// Per-slot local history and four saturating counters, trained by execute
////////////////////
`timescale 1ns/1ps

module history_table import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc_now,
    input  logic                  upd_vld,
    input  logic [addr_width-1:0] upd_pc,
    input  logic                  upd_slot,
    input  logic                  upd_taken,
    output logic                  past_vld1,
    output logic                  past_vld2,
    output logic [hist_width-1:0] past1,
    output logic [hist_width-1:0] past2
);

    logic [table_depth-1:0]                     rd_idx;
    logic [table_depth-1:0]                     wr_idx;
    logic [1:0][table_size-1:0]                 vld_q;
    logic [1:0][table_size-1:0][hist_width-1:0] hist_q;
    logic [hist_width-1:0]                      cur_entry;
    logic [hist_width-1:0]                      nxt_entry;
    logic [1:0]                                 cur_hist;
    logic [1:0]                                 cur_cnt;
    logic [1:0]                                 nxt_cnt;

    assign rd_idx = pc_now[idx_lo +: table_depth];
    assign wr_idx = upd_pc[idx_lo +: table_depth];

    ////////////////////
    // Training
    ////////////////////
    always_comb begin
        // A first update starts from a clean entry
        cur_entry = vld_q[upd_slot][wr_idx] ? hist_q[upd_slot][wr_idx] : '0;
        cur_hist  = cur_entry[hist_lo +: 2];
        cur_cnt   = cur_entry[2*cur_hist +: 2];
        if (upd_taken) begin
            nxt_cnt = (cur_cnt == 2'd3) ? cur_cnt : cur_cnt + 2'd1;
        end else begin
            nxt_cnt = (cur_cnt == 2'd0) ? cur_cnt : cur_cnt - 2'd1;
        end
        nxt_entry                   = cur_entry;
        nxt_entry[2*cur_hist +: 2]  = nxt_cnt;
        nxt_entry[hist_lo +: 2]     = {cur_hist[0], upd_taken};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q  <= '0;
            hist_q <= '0;
        end else if (upd_vld) begin
            vld_q[upd_slot][wr_idx]  <= 1'b1;
            hist_q[upd_slot][wr_idx] <= nxt_entry;
        end
    end

    assign past_vld1 = vld_q[0][rd_idx];
    assign past_vld2 = vld_q[1][rd_idx];
    assign past1     = hist_q[0][rd_idx];
    assign past2     = hist_q[1][rd_idx];

endmodule

// ==== hw/target_table.sv ====
////////////////////
// Target table
// Per-slot tagged entries with branch target and kind flags
////////////////////
`timescale 1ns/1ps

module target_table import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc_now,
    input  logic                  upd_vld,
    input  logic [addr_width-1:0] upd_pc,
    input  logic                  upd_slot,
    input  logic [addr_width-1:0] upd_target,
    input  logic [1:0]            upd_flags,
    output logic                  exist1,
    output logic                  exist2,
    output logic [addr_width-1:0] info1,
    output logic [addr_width-1:0] info2
);

    logic [table_depth-1:0]            rd_idx;
    logic [table_depth-1:0]            wr_idx;
    logic [tag_width-1:0]              rd_tag;
    logic [1:0][table_size-1:0]        vld_q;
    logic [tag_width-1:0]              tag_q  [2][table_size];
    logic [addr_width-1:0]             info_q [2][table_size];

    assign rd_idx = pc_now[idx_lo +: table_depth];
    assign wr_idx = upd_pc[idx_lo +: table_depth];
    assign rd_tag = pc_now[addr_width-1 -: tag_width];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= '0;
        end else if (upd_vld) begin
            vld_q[upd_slot][wr_idx] <= 1'b1;
        end
    end

    // Slot 0 holds the word at offset 0, slot 1 the word at offset 4
    always_ff @(posedge clk) begin
        if (upd_vld) begin
            tag_q[upd_slot][wr_idx]  <= upd_pc[addr_width-1 -: tag_width];
            info_q[upd_slot][wr_idx] <= {upd_target[addr_width-1:2], upd_flags};
        end
    end

    assign exist1 = vld_q[0][rd_idx] && (tag_q[0][rd_idx] == rd_tag);
    assign exist2 = vld_q[1][rd_idx] && (tag_q[1][rd_idx] == rd_tag);
    assign info1  = info_q[0][rd_idx];
    assign info2  = info_q[1][rd_idx];

endmodule

// ==== hw/bp_pkg.sv ====
////////////////////
// Branch predictor shared definitions
// Address slicing, table depths and entry field positions
////////////////////
package bp_pkg;

    // Fetch and target address width
    localparam int addr_width = 32;

    // All tables are indexed by pc bits 7:3
    localparam int table_depth = 5;
    localparam int table_size  = 1 << table_depth;
    localparam int idx_lo      = 3;

    // Tag is the pc above the index in bits 31:8
    localparam int tag_width = 24;

    // History sits in entry bits 9:8 and counter k in bits 2k+1:2k
    localparam int hist_width = 10;
    localparam int hist_lo    = 8;

    // Speculative history bits per slot
    localparam int guess_width = 2;

    // Info word flags below the target bits 31:2
    localparam int info_uncond = 1;
    localparam int info_cond   = 0;

endpackage
